// ==== logic/soc_pkg.sv ====
/*
 * Shared widths and encodings for the bus subsystem.
 * Modules import this package inside their bodies and use scoped
 * names for port widths in their headers.
 */
package soc_pkg;

  localparam int DATA_W = 16;  // bus data width
  localparam int ADDR_W = 19;  // word address, byte address bits 19:1

  // access class picked by the fabric
  typedef enum logic [2:0] {
    REGION_SRAM,
    REGION_ROM,
    REGION_DIAG,
    REGION_KBSTAT,
    REGION_IO_OTHER,
    REGION_INTA
  } region_e;

  // boot rom access sequencer
  typedef enum logic [1:0] {
    ROM_IDLE,
    ROM_WAIT,
    ROM_ACK
  } rom_state_e;

endpackage

// ==== logic/bus_fabric.sv ====
/*
 * Address decoder and bus multiplexer between the CPU master port and
 * the slaves. Gates strobes to SRAM and ROM, answers the local I/O
 * ports itself and returns the interrupt vector on inta cycles.
 */
`timescale 1ns/10ps

module bus_fabric (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic [soc_pkg::ADDR_W:1]    wb_adr_i,
  input  logic [soc_pkg::DATA_W-1:0]  wb_dat_i,
  input  logic                        wb_we_i,
  input  logic                        wb_tga_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_cyc_i,
  input  logic                        inta_i,
  input  logic [soc_pkg::DATA_W-1:0]  sram_dat_i,
  input  logic                        sram_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]  rom_dat_i,
  input  logic                        rom_ack_i,
  input  logic                        iid_i,
  output logic                        sram_stb_o,
  output logic                        rom_stb_o,
  output logic [soc_pkg::DATA_W-1:0]  wb_dat_o,
  output logic                        wb_ack_o,
  output logic [soc_pkg::DATA_W-1:0]  diag_o
);
  import soc_pkg::*;

  region_e      region;
  logic         bus_act;
  logic [3:0]   seg;         // memory segment, byte address 19:16
  logic         inta_ack_q;

  assign bus_act = wb_stb_i & wb_cyc_i;
  assign seg     = wb_adr_i[ADDR_W:ADDR_W-3];

  // inta overrides everything, then memory vs i/o space
  always_comb begin
    if (inta_i)
      region = REGION_INTA;
    else if (!wb_tga_i)
      region = (seg == 4'hc || seg == 4'hf) ? REGION_ROM : REGION_SRAM;
    else if (wb_adr_i[15:8] == 8'hf1)
      region = REGION_DIAG;
    else if (wb_adr_i[15:1] == 15'h0032 && !wb_we_i)
      region = REGION_KBSTAT;  // status read at port 0x64
    else
      region = REGION_IO_OTHER;
  end

  assign sram_stb_o = bus_act & (region == REGION_SRAM);
  assign rom_stb_o  = bus_act & (region == REGION_ROM);

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      diag_o <= '0;
    else if (bus_act && wb_we_i && region == REGION_DIAG)
      diag_o <= wb_dat_i;
  end

  // vector cycle acks one edge after it starts, pic has latched iid by then
  always_ff @(posedge clk) begin
    if (!rst_n_i)
      inta_ack_q <= 1'b0;
    else
      inta_ack_q <= bus_act & (region == REGION_INTA) & ~inta_ack_q;
  end

  always_comb begin
    case (region)
      REGION_SRAM:     wb_dat_o = sram_dat_i;
      REGION_ROM:      wb_dat_o = rom_dat_i;
      REGION_DIAG:     wb_dat_o = diag_o;
      REGION_KBSTAT:   wb_dat_o = DATA_W'(16'h0010);  // keyboard not inhibited
      REGION_INTA:     wb_dat_o = {{(DATA_W-4){1'b0}}, 3'b100, iid_i};
      default:         wb_dat_o = '0;
    endcase
  end

  always_comb begin
    case (region)
      REGION_SRAM:  wb_ack_o = sram_ack_i;
      REGION_ROM:   wb_ack_o = rom_ack_i;
      REGION_INTA:  wb_ack_o = inta_ack_q;
      default:      wb_ack_o = bus_act;  // local ports answer at once
    endcase
  end

endmodule

// ==== logic/sram_ctrl.sv ====
/*
 * Zero wait state word SRAM with byte write enables.
 * Read data and ack are registered, so both arrive one edge after
 * the strobe. Address bits above RAM_AW alias.
 */
`timescale 1ns/10ps

module sram_ctrl #(
  parameter int RAM_AW = 12
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [soc_pkg::DATA_W/8-1:0]  sel_i,
  input  logic [soc_pkg::ADDR_W:1]      adr_i,
  input  logic [soc_pkg::DATA_W-1:0]    dat_i,
  output logic [soc_pkg::DATA_W-1:0]    dat_o,
  output logic                          ack_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] mem [0:2**RAM_AW-1];
  logic [RAM_AW-1:0] idx;
  logic              access;

  assign idx    = adr_i[RAM_AW:1];
  assign access = stb_i & ~ack_o;  // held strobe during ack is not a new access

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      ack_o <= 1'b0;
    else
      ack_o <= access;
  end

  always_ff @(posedge clk) begin
    if (access && we_i) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (sel_i[b])
          mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
      end
    end
    dat_o <= mem[idx];  // old word on a write cycle
  end

endmodule

// ==== logic/boot_rom.sv ====
/*
 * Boot ROM behind segments C and F, loaded from boot_rom.hex.
 * Each access is held off for ROM_WAIT cycles and then acked for one
 * cycle. Writes get an ack and change nothing.
 */
`timescale 1ns/10ps

module boot_rom #(
  parameter int ROM_AW   = 5,
  parameter int ROM_WAIT = 3
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        stb_i,
  input  logic [soc_pkg::ADDR_W:1]    adr_i,
  output logic [soc_pkg::DATA_W-1:0]  dat_o,
  output logic                        ack_o
);
  import soc_pkg::*;

  localparam int CNT_W = (ROM_WAIT > 1) ? $clog2(ROM_WAIT) : 1;

  logic [DATA_W-1:0] mem [0:2**ROM_AW-1];
  logic [ROM_AW-1:0] idx;
  rom_state_e        state;
  logic [CNT_W-1:0]  wait_cnt;

  initial begin
    $readmemh("boot_rom.hex", mem);
  end

  assign idx   = adr_i[ROM_AW:1];
  assign ack_o = (state == ROM_ACK);

  always_ff @(posedge clk) begin
    dat_o <= mem[idx];
  end

  // the wait parameter hides the package state name, hence the scoped form
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state    <= ROM_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        ROM_IDLE: begin
          wait_cnt <= '0;
          if (stb_i)
            state <= (ROM_WAIT == 0) ? ROM_ACK : soc_pkg::ROM_WAIT;
        end
        soc_pkg::ROM_WAIT: begin
          if (!stb_i)
            state <= ROM_IDLE;  // master gave up
          else if (wait_cnt == CNT_W'(ROM_WAIT - 1))
            state <= ROM_ACK;
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        ROM_ACK:  state <= ROM_IDLE;  // single cycle ack
        default:  state <= ROM_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/interval_timer.sv ====
/*
 * Free running interval timer. Emits a one cycle tick every
 * TIMER_PERIOD clocks, used as interrupt line 0.
 */
`timescale 1ns/10ps

module interval_timer #(
  parameter int TIMER_PERIOD = 200
) (
  input  logic clk,
  input  logic rst_n_i,
  output logic tick_o
);

  localparam int CNT_W = (TIMER_PERIOD > 1) ? $clog2(TIMER_PERIOD) : 1;

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count  <= '0;
      tick_o <= 1'b0;
    end else if (count == CNT_W'(TIMER_PERIOD - 1)) begin
      count  <= '0;     // wrap
      tick_o <= 1'b1;
    end else begin
      count  <= count + 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== logic/simple_pic.sv ====
/*
 * Two input interrupt controller. Rising edges on irq_i set pending
 * bits, intr_o is high while any is pending. On the rising edge of
 * inta_i the lowest pending line is stored in iid_o and cleared.
 */
`timescale 1ns/10ps

module simple_pic (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [1:0] irq_i,   // 0 timer, 1 external
  input  logic       inta_i,
  output logic       intr_o,
  output logic       iid_o
);

  logic [1:0] irq_q;
  logic       inta_q;
  logic [1:0] pending;
  logic [1:0] set_mask;
  logic [1:0] clr_mask;
  logic       inta_rise;

  assign set_mask  = irq_i & ~irq_q;
  assign inta_rise = inta_i & ~inta_q;

  // line 0 wins when both are pending
  always_comb begin
    clr_mask = 2'b00;
    if (inta_rise) begin
      if (pending[0])
        clr_mask = 2'b01;
      else if (pending[1])
        clr_mask = 2'b10;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      irq_q   <= 2'b00;
      inta_q  <= 1'b0;
      pending <= 2'b00;
      iid_o   <= 1'b0;
    end else begin
      irq_q   <= irq_i;
      inta_q  <= inta_i;
      pending <= (pending & ~clr_mask) | set_mask;  // a new edge re-arms
      if (clr_mask != 2'b00)
        iid_o <= clr_mask[1];
    end
  end

  assign intr_o = |pending;

endmodule

// ==== logic/soc_top.sv ====
/*
 * Bus subsystem top level. The CPU master port comes in as loose
 * ports; fabric, SRAM, boot ROM, timer and PIC are wired up here.
 */
`timescale 1ns/10ps

module soc_top #(
  parameter int RAM_AW       = 12,
  parameter int ROM_AW       = 5,
  parameter int ROM_WAIT     = 3,
  parameter int TIMER_PERIOD = 200
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [soc_pkg::ADDR_W:1]      wb_adr_i,
  input  logic [soc_pkg::DATA_W-1:0]    wb_dat_i,
  output logic [soc_pkg::DATA_W-1:0]    wb_dat_o,
  input  logic                          wb_we_i,
  input  logic                          wb_tga_i,
  input  logic [soc_pkg::DATA_W/8-1:0]  wb_sel_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_cyc_i,
  output logic                          wb_ack_o,
  input  logic                          inta_i,
  output logic                          intr_o,
  input  logic                          irq_ext_i,
  output logic [soc_pkg::DATA_W-1:0]    diag_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] sram_dat;
  logic              sram_stb;
  logic              sram_ack;
  logic [DATA_W-1:0] rom_dat;
  logic              rom_stb;
  logic              rom_ack;
  logic              timer_tick;
  logic              iid;

  bus_fabric bus_fabric_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_we_i    (wb_we_i),
    .wb_tga_i   (wb_tga_i),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .inta_i     (inta_i),
    .sram_dat_i (sram_dat),
    .sram_ack_i (sram_ack),
    .rom_dat_i  (rom_dat),
    .rom_ack_i  (rom_ack),
    .iid_i      (iid),
    .sram_stb_o (sram_stb),
    .rom_stb_o  (rom_stb),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .diag_o     (diag_o)
  );

  sram_ctrl #(
    .RAM_AW (RAM_AW)
  ) sram_ctrl_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (sram_stb),
    .we_i    (wb_we_i),
    .sel_i   (wb_sel_i),
    .adr_i   (wb_adr_i),
    .dat_i   (wb_dat_i),
    .dat_o   (sram_dat),
    .ack_o   (sram_ack)
  );

  boot_rom #(
    .ROM_AW   (ROM_AW),
    .ROM_WAIT (ROM_WAIT)
  ) boot_rom_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (rom_stb),
    .adr_i   (wb_adr_i),
    .dat_o   (rom_dat),
    .ack_o   (rom_ack)
  );

  interval_timer #(
    .TIMER_PERIOD (TIMER_PERIOD)
  ) interval_timer_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .tick_o  (timer_tick)
  );

  simple_pic simple_pic_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .irq_i   ({irq_ext_i, timer_tick}),  // external stands in for keyboard
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

endmodule

// ==== test/tb_soc.sv ====
/*
 * Testbench for the bus subsystem. Acts as the CPU on the master port,
 * runs random SRAM, ROM and I/O traffic from a fixed seed against a
 * model, then checks interrupt delivery and priority.
 */
`timescale 1ns/10ps

module tb_soc;
  import soc_pkg::*;

  localparam int RAM_AW       = 12;
  localparam int ROM_AW       = 5;
  localparam int ROM_WAIT     = 3;
  localparam int TIMER_PERIOD = 200;
  localparam int ACK_LIMIT    = 16;  // cycles

  logic                clk = 1'b0;
  logic                rst_n_i;
  logic [ADDR_W:1]     wb_adr_i;
  logic [DATA_W-1:0]   wb_dat_i;
  logic [DATA_W-1:0]   wb_dat_o;
  logic                wb_we_i;
  logic                wb_tga_i;
  logic [DATA_W/8-1:0] wb_sel_i;
  logic                wb_stb_i;
  logic                wb_cyc_i;
  logic                wb_ack_o;
  logic                inta_i;
  logic                intr_o;
  logic                irq_ext_i;
  logic [DATA_W-1:0]   diag_o;

  logic [DATA_W-1:0] sram_model [0:2**RAM_AW-1];
  logic [DATA_W-1:0] rom_model [0:2**ROM_AW-1];
  logic [DATA_W-1:0] diag_model;

  soc_top #(
    .RAM_AW       (RAM_AW),
    .ROM_AW       (ROM_AW),
    .ROM_WAIT     (ROM_WAIT),
    .TIMER_PERIOD (TIMER_PERIOD)
  ) soc_top_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_we_i   (wb_we_i),
    .wb_tga_i  (wb_tga_i),
    .wb_sel_i  (wb_sel_i),
    .wb_stb_i  (wb_stb_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_ack_o  (wb_ack_o),
    .inta_i    (inta_i),
    .intr_o    (intr_o),
    .irq_ext_i (irq_ext_i),
    .diag_o    (diag_o)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_value(input string name, input logic [15:0] act,
                               input logic [15:0] want);
    if (act !== want) begin
      $display("ERR %0t %s actual=%h expected=%h", $time, name, act, want);
      fail_run("value mismatch");
    end
  endtask

  // edges from the first strobed edge until ack, by access class
  function automatic int ack_latency(input logic tga, input logic inta,
                                     input logic [ADDR_W:1] adr);
    if (inta)
      return 1;
    if (tga)
      return 0;  // local i/o ports answer in the same cycle
    if (adr[ADDR_W:ADDR_W-3] == 4'hc || adr[ADDR_W:ADDR_W-3] == 4'hf)
      return ROM_WAIT + 1;
    return 1;
  endfunction

  // one master cycle, entered and left just after a rising edge
  task automatic bus_access(input logic tga, input logic we, input logic inta,
                            input logic [ADDR_W:1] adr, input logic [15:0] wdat,
                            input logic [1:0] sel, output logic [15:0] rdat);
    int n;
    int want_lat;
    n = 0;
    want_lat = ack_latency(tga, inta, adr);
    wb_tga_i = tga;
    wb_we_i  = we;
    inta_i   = inta;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    wb_sel_i = sel;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    @(negedge clk);
    while (!wb_ack_o && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack_o)
      fail_run("bus access got no ack within the time limit");
    compare_value("wb_ack_o latency", 16'(n), 16'(want_lat));
    rdat = wb_dat_o;
    @(posedge clk);  // master takes ack here
    #2;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    inta_i   = 1'b0;
    @(posedge clk);  // one idle cycle between accesses
    #2;
  endtask

  task automatic wait_intr();
    int n;
    n = 0;
    while (!intr_o && n < 2*TIMER_PERIOD) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!intr_o)
      fail_run("intr_o did not rise within the time limit");
  endtask

  task automatic pulse_ext_irq();
    irq_ext_i = 1'b1;
    @(posedge clk);
    #2;
    irq_ext_i = 1'b0;
  endtask

  task automatic int_ack(input logic [15:0] want);
    logic [15:0] v;
    bus_access(1'b0, 1'b0, 1'b1, '0, '0, 2'b00, v);
    compare_value("wb_dat_o vector", v, want);
  endtask

  // memory address outside segments C and F, low index kept small so hits repeat
  function automatic logic [ADDR_W:1] sram_addr();
    logic [31:0]     r;
    logic [ADDR_W:1] a;
    r = $urandom;
    a = r[ADDR_W:1];
    a[RAM_AW:6] = '0;
    if (a[ADDR_W:ADDR_W-3] == 4'hc || a[ADDR_W:ADDR_W-3] == 4'hf)
      a[ADDR_W:ADDR_W-3] = a[ADDR_W:ADDR_W-3] ^ 4'h2;  // c to e, f to d
    return a;
  endfunction

  initial begin
    logic [31:0]     r;
    logic [ADDR_W:1] a;
    logic [15:0]     d;
    logic [15:0]     rd;
    logic [1:0]      sel;
    logic            we;
    rst_n_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_tga_i  = 1'b0;
    wb_sel_i  = '0;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    inta_i    = 1'b0;
    irq_ext_i = 1'b0;
    r = $urandom(55);
    $readmemh("boot_rom.hex", rom_model);
    repeat (5) @(posedge clk);
    #2 rst_n_i = 1'b1;
    @(posedge clk);
    #2;
    compare_value("wb_ack_o", {15'b0, wb_ack_o}, 16'h0000);
    compare_value("intr_o", {15'b0, intr_o}, 16'h0000);
    compare_value("diag_o", diag_o, 16'h0000);

    // fill the window first so no read sees an unwritten word
    for (int i = 0; i < 32; i++) begin
      r = $urandom;
      a = sram_addr();
      a[5:1] = i[4:0];
      bus_access(1'b0, 1'b1, 1'b0, a, r[15:0], 2'b11, rd);
      sram_model[a[RAM_AW:1]] = r[15:0];
    end
    for (int i = 0; i < 300; i++) begin
      r   = $urandom;
      a   = sram_addr();
      d   = r[15:0];
      sel = r[17:16];
      we  = r[18];
      bus_access(1'b0, we, 1'b0, a, d, sel, rd);
      if (we) begin
        if (sel[0])
          sram_model[a[RAM_AW:1]][7:0] = d[7:0];
        if (sel[1])
          sram_model[a[RAM_AW:1]][15:8] = d[15:8];
      end else begin
        compare_value("wb_dat_o sram", rd, sram_model[a[RAM_AW:1]]);
      end
    end

    // rom in segments c and f, writes mixed in
    for (int i = 0; i < 40; i++) begin
      r = $urandom;
      a = r[ADDR_W:1];
      a[ADDR_W:ADDR_W-3] = r[31] ? 4'hf : 4'hc;
      we = r[30];
      bus_access(1'b0, we, 1'b0, a, ~r[15:0], 2'b11, rd);
      if (!we)
        compare_value("wb_dat_o rom", rd, rom_model[a[ROM_AW:1]]);
    end

    for (int i = 0; i < 8; i++) begin
      r = $urandom;
      a = '0;
      a[15:1] = {8'hf1, r[7:1]};
      diag_model = r[31:16];
      bus_access(1'b1, 1'b1, 1'b0, a, diag_model, 2'b11, rd);
      compare_value("diag_o", diag_o, diag_model);
      a[15:1] = r[15:1];
      if (a[15:8] == 8'hf1)
        a[15] = 1'b0;
      bus_access(1'b1, 1'b1, 1'b0, a, ~diag_model, 2'b11, rd);
      compare_value("diag_o", diag_o, diag_model);  // other port, no effect
      if (a[15:1] == 15'h0032)
        a[2] = ~a[2];  // keep off the keyboard status port
      bus_access(1'b1, 1'b0, 1'b0, a, '0, 2'b11, rd);
      compare_value("wb_dat_o io", rd, 16'h0000);
    end
    a = '0;
    a[15:1] = 15'h0032;  // port 0x64
    bus_access(1'b1, 1'b0, 1'b0, a, '0, 2'b11, rd);
    compare_value("wb_dat_o kbstat", rd, 16'h0010);

    // timer has been ticking all along
    if (intr_o)
      int_ack(16'h0008);
    wait_intr();
    int_ack(16'h0008);  // now right after a tick, next one far away
    pulse_ext_irq();
    wait_intr();
    int_ack(16'h0009);
    compare_value("intr_o", {15'b0, intr_o}, 16'h0000);

    // both pending, timer line wins
    wait_intr();
    pulse_ext_irq();
    int_ack(16'h0008);
    compare_value("intr_o", {15'b0, intr_o}, 16'h0001);
    int_ack(16'h0009);
    compare_value("intr_o", {15'b0, intr_o}, 16'h0000);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== boot_rom.hex ====
// boot ROM image, one 16-bit word per line, hex
// word address 0 upward, 32 words
ea5b
00e0
00f0
fa31
c08e
d08e
bc00
7cfb
b800
f18e
c0ba
01f1
ef90
e464
a810
75fa
be40
00ac
3c00
7405
e8f2
00eb
f6f4
ebfd
55aa
1234
4321
a5c3
0f1e
2d3c
4b5a
6978

// ==== all.f ====
logic/soc_pkg.sv
logic/bus_fabric.sv
logic/sram_ctrl.sv
logic/boot_rom.sv
logic/interval_timer.sv
logic/simple_pic.sv
logic/soc_top.sv
test/tb_soc.sv

// ==== Makefile ====
# Verilator flow for the bus subsystem
# make        build the testbench and run it
# make lint   lint the RTL top level
# make clean  remove build output

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f all.f --top-module tb_soc
	./obj_dir/Vtb_soc

lint:
	verilator --lint-only --timing -f all.f --top-module soc_top

clean:
	rm -rf obj_dir
